//--- verilog/frag_write_pkg.sv
package frag_write_pkg;

    // Fragment core array
    localparam int num_cores = 8;
    localparam int core_id_w = 3;     // Index of one core

    // Screen coordinates and framebuffer width share one width
    localparam int coord_w = 16;

    // Framebuffer byte address and base register
    localparam int addr_w = 32;

    // RGBA pixel word, also the APB data width
    localparam int data_w = 32;

    // Four bytes per pixel
    localparam int pixel_shift = 2;

    // Completed-write counter, wraps
    localparam int cnt_w = 16;

    // APB register map
    localparam int paddr_w = 4;
    localparam logic [paddr_w-1:0] reg_fb_base     = 4'h0;
    localparam logic [paddr_w-1:0] reg_fb_width    = 4'h4;
    localparam logic [paddr_w-1:0] reg_write_count = 4'h8;    // Any write clears

endpackage

//--- verilog/write_arb_fsm.sv
module write_arb_fsm (
    input  logic clk,
    input  logic rst_n,
    input  logic req_found,
    input  logic write_complete,
    output logic capture,
    output logic grant_phase,
    output logic done_phase,
    output logic start_write,
    output logic write_retired
);

    // One framebuffer write per pass through the sequence
    typedef enum logic [2:0] {
        st_idle          = 3'd0,
        st_find_request  = 3'd1,
        st_process_write = 3'd2,
        st_wait_complete = 3'd3,
        st_send_response = 3'd4
    } arb_state_t;

    arb_state_t state;
    arb_state_t state_next;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= st_idle;
        end else begin
            state <= state_next;
        end
    end

    always_comb begin
        state_next = state;
        case (state)
            st_idle: begin
                if (req_found) begin
                    state_next = st_find_request;
                end
            end
            st_find_request: begin
                state_next = st_process_write;
            end
            st_process_write: begin
                state_next = st_wait_complete;
            end
            st_wait_complete: begin
                // Master back-pressure holds us here
                if (write_complete) begin
                    state_next = st_send_response;
                end
            end
            st_send_response: begin
                state_next = st_idle;
            end
            default: begin
                state_next = st_idle;
            end
        endcase
    end

    // Winner and pixel data latched at the end of find-request
    assign capture = (state == st_find_request);

    assign grant_phase = (state == st_process_write);
    assign start_write = (state == st_process_write);    // One-cycle strobe to master

    // Done pulse to the core and count increment share a cycle
    assign done_phase    = (state == st_send_response);
    assign write_retired = (state == st_send_response);

endmodule

//--- verilog/core_select.sv
module core_select import frag_write_pkg::*; (
    input  logic                              clk,
    input  logic                              rst_n,
    input  logic [num_cores-1:0]              write_req,
    input  logic [num_cores-1:0][coord_w-1:0] write_x,
    input  logic [num_cores-1:0][coord_w-1:0] write_y,
    input  logic [num_cores-1:0][data_w-1:0]  write_color,
    input  logic                              capture,
    input  logic                              grant_phase,
    input  logic                              done_phase,
    output logic                              req_found,
    output logic [core_id_w-1:0]              requesting_core_id,
    output logic [coord_w-1:0]                sel_x,
    output logic [coord_w-1:0]                sel_y,
    output logic [data_w-1:0]                 sel_color,
    output logic [num_cores-1:0]              write_valid,
    output logic [num_cores-1:0]              write_done
);

    logic [core_id_w-1:0] winner;
    logic [core_id_w-1:0] active_id;    // Core owning the current write
    logic [core_id_w-1:0] sel_id;

    // Fixed priority, lowest index wins
    always_comb begin
        winner    = '0;
        req_found = 1'b0;
        for (int k = num_cores - 1; k >= 0; k--) begin
            if (write_req[k]) begin
                winner    = core_id_w'(k);
                req_found = 1'b1;
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            active_id <= '0;
        end else if (capture) begin
            active_id <= winner;
        end
    end

    // During capture the latch is not loaded yet, so the live winner
    // feeds the address unit; cores hold their fields until done
    assign sel_id = capture ? winner : active_id;

    assign sel_x     = write_x[sel_id];
    assign sel_y     = write_y[sel_id];
    assign sel_color = write_color[sel_id];

    assign requesting_core_id = active_id;

    // One-hot responses back to the cores
    always_comb begin
        write_valid = '0;
        write_done  = '0;
        for (int k = 0; k < num_cores; k++) begin
            if (active_id == core_id_w'(k)) begin
                write_valid[k] = grant_phase;
                write_done[k]  = done_phase;
            end
        end
    end

endmodule

//--- verilog/fb_address_unit.sv
module fb_address_unit import frag_write_pkg::*; (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               capture,
    input  logic [coord_w-1:0] sel_x,
    input  logic [coord_w-1:0] sel_y,
    input  logic [data_w-1:0]  sel_color,
    input  logic [addr_w-1:0]  fb_base,
    input  logic [coord_w-1:0] fb_width,
    output logic [addr_w-1:0]  write_address,
    output logic [data_w-1:0]  write_value
);

    logic [addr_w-1:0] pixel_index;    // y * width + x
    logic [addr_w-1:0] byte_address;

    // All arithmetic wraps at 2^32
    always_comb begin
        pixel_index  = addr_w'(sel_y) * addr_w'(fb_width) + addr_w'(sel_x);
        byte_address = fb_base + (pixel_index << pixel_shift);
    end

    // Held until the next grant
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            write_address <= '0;
            write_value   <= '0;
        end else if (capture) begin
            write_address <= byte_address;
            write_value   <= sel_color;
        end
    end

endmodule

//--- verilog/write_counter.sv
module write_counter import frag_write_pkg::*; (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             write_retired,
    input  logic             count_clear,
    output logic [cnt_w-1:0] write_count
);

    // Software clear wins over a retiring write
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            write_count <= '0;
        end else if (count_clear) begin
            write_count <= '0;
        end else if (write_retired) begin
            write_count <= write_count + cnt_w'(1);    // Wraps at 2^16
        end
    end

endmodule

//--- verilog/apb_regs.sv
module apb_regs import frag_write_pkg::*; (
    input  logic               clk,
    input  logic               rst_n,
    input  logic               psel,
    input  logic               penable,
    input  logic               pwrite,
    input  logic [paddr_w-1:0] paddr,
    input  logic [data_w-1:0]  pwdata,
    input  logic [cnt_w-1:0]   write_count,
    output logic [data_w-1:0]  prdata,
    output logic               pslverr,
    output logic [addr_w-1:0]  fb_base,
    output logic [coord_w-1:0] fb_width,
    output logic               count_clear
);

    logic access;       // Access phase, no wait states
    logic wr_access;
    logic hit_base;
    logic hit_width;
    logic hit_count;
    logic mapped;

    assign access    = psel && penable;
    assign wr_access = access && pwrite;

    // Offset decode
    assign hit_base  = (paddr == reg_fb_base);
    assign hit_width = (paddr == reg_fb_width);
    assign hit_count = (paddr == reg_write_count);
    assign mapped    = hit_base || hit_width || hit_count;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            fb_base  <= '0;
            fb_width <= '0;
        end else if (wr_access) begin
            if (hit_base) begin
                fb_base <= pwdata[addr_w-1:0];
            end
            if (hit_width) begin
                fb_width <= pwdata[coord_w-1:0];    // Upper bits dropped
            end
        end
    end

    // Data is ignored, the write itself clears
    assign count_clear = wr_access && hit_count;

    always_comb begin
        case (paddr)
            reg_fb_base: begin
                prdata = data_w'(fb_base);
            end
            reg_fb_width: begin
                prdata = data_w'(fb_width);
            end
            reg_write_count: begin
                prdata = data_w'(write_count);
            end
            default: begin
                prdata = '0;
            end
        endcase
    end

    // Unmapped offsets error out in the access cycle
    assign pslverr = access && !mapped;

endmodule

//--- verilog/frag_write_top.sv
module frag_write_top import frag_write_pkg::*; (
    input  logic                              clk,
    input  logic                              rst_n,

    // Fragment cores
    input  logic [num_cores-1:0]              write_req,
    input  logic [num_cores-1:0][coord_w-1:0] write_x,
    input  logic [num_cores-1:0][coord_w-1:0] write_y,
    input  logic [num_cores-1:0][data_w-1:0]  write_color,
    output logic [num_cores-1:0]              write_valid,
    output logic [num_cores-1:0]              write_done,

    // Write master
    output logic                              start_write,
    output logic [addr_w-1:0]                 write_address,
    output logic [data_w-1:0]                 write_value,
    output logic [core_id_w-1:0]              requesting_core_id,
    input  logic                              write_complete,

    // APB configuration port
    input  logic                              psel,
    input  logic                              penable,
    input  logic                              pwrite,
    input  logic [paddr_w-1:0]                paddr,
    input  logic [data_w-1:0]                 pwdata,
    output logic [data_w-1:0]                 prdata,
    output logic                              pslverr
);

    logic               req_found;
    logic               capture;
    logic               grant_phase;
    logic               done_phase;
    logic               write_retired;
    logic [coord_w-1:0] sel_x;
    logic [coord_w-1:0] sel_y;
    logic [data_w-1:0]  sel_color;
    logic [addr_w-1:0]  fb_base;
    logic [coord_w-1:0] fb_width;
    logic               count_clear;
    logic [cnt_w-1:0]   write_count;

    write_arb_fsm u_fsm (
        .clk            (clk),
        .rst_n          (rst_n),
        .req_found      (req_found),
        .write_complete (write_complete),
        .capture        (capture),
        .grant_phase    (grant_phase),
        .done_phase     (done_phase),
        .start_write    (start_write),
        .write_retired  (write_retired)
    );

    core_select u_select (
        .clk                (clk),
        .rst_n              (rst_n),
        .write_req          (write_req),
        .write_x            (write_x),
        .write_y            (write_y),
        .write_color        (write_color),
        .capture            (capture),
        .grant_phase        (grant_phase),
        .done_phase         (done_phase),
        .req_found          (req_found),
        .requesting_core_id (requesting_core_id),
        .sel_x              (sel_x),
        .sel_y              (sel_y),
        .sel_color          (sel_color),
        .write_valid        (write_valid),
        .write_done         (write_done)
    );

    fb_address_unit u_addr (
        .clk           (clk),
        .rst_n         (rst_n),
        .capture       (capture),
        .sel_x         (sel_x),
        .sel_y         (sel_y),
        .sel_color     (sel_color),
        .fb_base       (fb_base),
        .fb_width      (fb_width),
        .write_address (write_address),
        .write_value   (write_value)
    );

    write_counter u_count (
        .clk           (clk),
        .rst_n         (rst_n),
        .write_retired (write_retired),
        .count_clear   (count_clear),
        .write_count   (write_count)
    );

    apb_regs u_regs (
        .clk         (clk),
        .rst_n       (rst_n),
        .psel        (psel),
        .penable     (penable),
        .pwrite      (pwrite),
        .paddr       (paddr),
        .pwdata      (pwdata),
        .write_count (write_count),
        .prdata      (prdata),
        .pslverr     (pslverr),
        .fb_base     (fb_base),
        .fb_width    (fb_width),
        .count_clear (count_clear)
    );

endmodule

//--- tests/tb_frag_write.sv
module tb_frag_write import frag_write_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int num_random_writes = 300;
    localparam int max_bursts        = num_random_writes / 8 + 1;
    localparam int apb_cycles        = (max_bursts * 7 + 12) * 3;    // 3 cycles per transfer
    localparam int timeout_cycles    = (num_random_writes + num_cores) * 16 + apb_cycles + 500;

    // Reference FSM phases
    localparam int ph_idle = 0;
    localparam int ph_find = 1;
    localparam int ph_proc = 2;
    localparam int ph_wait = 3;
    localparam int ph_resp = 4;

    logic                              clk;
    logic                              rst_n;
    logic [num_cores-1:0]              write_req;
    logic [num_cores-1:0][coord_w-1:0] write_x;
    logic [num_cores-1:0][coord_w-1:0] write_y;
    logic [num_cores-1:0][data_w-1:0]  write_color;
    logic [num_cores-1:0]              write_valid;
    logic [num_cores-1:0]              write_done;
    logic                              start_write;
    logic [addr_w-1:0]                 write_address;
    logic [data_w-1:0]                 write_value;
    logic [core_id_w-1:0]              requesting_core_id;
    logic                              write_complete;
    logic                              psel;
    logic                              penable;
    logic                              pwrite;
    logic [paddr_w-1:0]                paddr;
    logic [data_w-1:0]                 pwdata;
    logic [data_w-1:0]                 prdata;
    logic                              pslverr;

    logic [31:0]          lcg_state;
    int                   cycle_count;
    logic                 models_on;
    int                   ref_phase;
    logic [core_id_w-1:0] exp_core;
    logic [addr_w-1:0]    exp_addr;
    logic [data_w-1:0]    exp_color;
    logic [addr_w-1:0]    ref_base;      // Mirror of the APB registers
    logic [coord_w-1:0]   ref_width;
    logic [cnt_w-1:0]     ref_count;
    int                   master_wait;
    int                   requests_left;
    int                   issued_total;
    int                   done_total;
    int                   random_issued;
    int                   burst;
    logic [data_w-1:0]    rdata;
    logic                 err;

    frag_write_top dut0 (
        .clk                (clk),
        .rst_n              (rst_n),
        .write_req          (write_req),
        .write_x            (write_x),
        .write_y            (write_y),
        .write_color        (write_color),
        .write_valid        (write_valid),
        .write_done         (write_done),
        .start_write        (start_write),
        .write_address      (write_address),
        .write_value        (write_value),
        .requesting_core_id (requesting_core_id),
        .write_complete     (write_complete),
        .psel               (psel),
        .penable            (penable),
        .pwrite             (pwrite),
        .paddr              (paddr),
        .pwdata             (pwdata),
        .prdata             (prdata),
        .pslverr            (pslverr)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic int rand_below(input int n);
        logic [31:0] r;
        r = next_rand();
        return int'(r[30:16]) % n;    // Upper bits are the better ones
    endfunction

    function automatic logic [31:0] rand_word();
        logic [31:0] hi;
        logic [31:0] lo;
        hi = next_rand();
        lo = next_rand();
        return {hi[31:16], lo[31:16]};
    endfunction

    function automatic logic [core_id_w-1:0] lowest_index(input logic [num_cores-1:0] req);
        for (int k = 0; k < num_cores; k++) begin
            if (req[k]) return core_id_w'(k);
        end
        return '0;
    endfunction

    // base + (y * width + x) * 4, wrapping at 2^32
    function automatic logic [31:0] pixel_address(input logic [31:0] base,
            input logic [15:0] width, input logic [15:0] x, input logic [15:0] y);
        logic [31:0] index;
        index = 32'(y) * 32'(width) + 32'(x);
        return base + index * 32'd4;
    endfunction

    task automatic check_value(input string name, input logic [31:0] expected,
            input logic [31:0] actual);
        if (expected !== actual) begin
            $display("FAIL %s: expected %h, got %h", name, expected, actual);
            $display("Test failed");
            $fatal(1, "stopped at first mismatch");
        end
    endtask

    task automatic post_request(input logic [core_id_w-1:0] c);
        logic [31:0] r;
        r = rand_word();
        write_req[c]   <= 1'b1;
        write_x[c]     <= r[15:0];
        write_y[c]     <= r[31:16];
        write_color[c] <= rand_word();
        issued_total++;
    endtask

    task automatic step_cores();
        logic [core_id_w-1:0] c;
        for (int k = 0; k < num_cores; k++) begin
            c = core_id_w'(k);
            if (write_done[c]) begin
                write_req[c] <= 1'b0;    // Dropped on the done edge
                done_total++;
            end else if (!write_req[c] && requests_left > 0 && rand_below(4) == 0) begin
                post_request(c);
                requests_left--;
            end
        end
    endtask

    task automatic step_master();
        write_complete <= 1'b0;
        if (master_wait > 0) begin
            master_wait--;
            if (master_wait == 0) write_complete <= 1'b1;
        end
        if (start_write) master_wait = 1 + rand_below(8);
    endtask

    // Values read here are the ones just before the edge
    task automatic step_reference();
        logic [num_cores-1:0] onehot;
        onehot = num_cores'(1) << exp_core;
        check_value("start_write", 32'(ref_phase == ph_proc), 32'(start_write));
        check_value("write_valid", (ref_phase == ph_proc) ? 32'(onehot) : 32'h0,
                    32'(write_valid));
        check_value("write_done", (ref_phase == ph_resp) ? 32'(onehot) : 32'h0,
                    32'(write_done));
        if (ref_phase == ph_proc) begin
            check_value("requesting_core_id", 32'(exp_core), 32'(requesting_core_id));
            check_value("write_address", exp_addr, write_address);
            check_value("write_value", exp_color, write_value);
        end
        case (ref_phase)
            ph_idle: begin
                if (write_req != '0) begin
                    ref_phase = ph_find;
                end
            end
            ph_find: begin
                // Winner decided at the end of find-request
                exp_core  = lowest_index(write_req);
                exp_addr  = pixel_address(ref_base, ref_width, write_x[exp_core],
                                          write_y[exp_core]);
                exp_color = write_color[exp_core];
                ref_phase = ph_proc;
            end
            ph_proc: ref_phase = ph_wait;
            ph_wait: begin
                if (write_complete) ref_phase = ph_resp;
            end
            default: begin
                ref_count = ref_count + 16'd1;
                ref_phase = ph_idle;
            end
        endcase
    endtask

    task automatic tick();
        @(posedge clk);
        cycle_count++;
        if (cycle_count > timeout_cycles) begin
            $display("Timeout: run not finished after %0d clock cycles", timeout_cycles);
            $display("Test failed");
            $fatal(1, "stopped on timeout");
        end
        if (models_on) begin
            step_reference();
            step_master();
            step_cores();
        end
    endtask

    // Setup cycle then access cycle, no wait states
    task automatic apb_transfer(input logic wr, input logic [paddr_w-1:0] addr,
            input logic [data_w-1:0] wdata, output logic [data_w-1:0] rd, output logic er);
        tick();
        psel    <= 1'b1;
        penable <= 1'b0;
        pwrite  <= wr;
        paddr   <= addr;
        pwdata  <= wdata;
        tick();
        penable <= 1'b1;
        tick();
        rd = prdata;
        er = pslverr;
        psel    <= 1'b0;
        penable <= 1'b0;
    endtask

    task automatic reg_write(input logic [paddr_w-1:0] addr, input logic [data_w-1:0] data);
        apb_transfer(1'b1, addr, data, rdata, err);
        check_value("pslverr", 32'h0, 32'(err));
    endtask

    task automatic reg_expect(input string name, input logic [paddr_w-1:0] addr,
            input logic [data_w-1:0] expected);
        apb_transfer(1'b0, addr, 32'h0, rdata, err);
        check_value("pslverr", 32'h0, 32'(err));
        check_value(name, expected, rdata);
    endtask

    task automatic reprogram_fb();
        logic [31:0] base;
        logic [31:0] width;
        base  = rand_word();
        width = rand_word();
        reg_write(reg_fb_base, base);
        reg_write(reg_fb_width, width);
        ref_base  = base;
        ref_width = width[15:0];
        reg_expect("prdata fb_base", reg_fb_base, base);
        reg_expect("prdata fb_width", reg_fb_width, {16'h0, width[15:0]});
    endtask

    task automatic clear_count();
        reg_write(reg_write_count, rand_word());    // Any data clears
        ref_count = '0;
        reg_expect("prdata write_count", reg_write_count, 32'h0);
    endtask

    task automatic wait_idle();
        while (requests_left > 0 || issued_total != done_total || ref_phase != ph_idle) begin
            tick();
        end
    endtask

    initial begin
        lcg_state     = 32'd61970;
        cycle_count   = 0;
        models_on     = 1'b0;
        ref_phase     = ph_idle;
        exp_core      = '0;
        ref_base      = '0;
        ref_width     = '0;
        ref_count     = '0;
        master_wait   = 0;
        requests_left = 0;
        issued_total  = 0;
        done_total    = 0;
        random_issued = 0;
        rst_n          <= 1'b0;
        write_req      <= '0;
        write_x        <= '0;
        write_y        <= '0;
        write_color    <= '0;
        write_complete <= 1'b0;
        psel           <= 1'b0;
        penable        <= 1'b0;
        pwrite         <= 1'b0;
        paddr          <= '0;
        pwdata         <= '0;
        tick();
        tick();
        rst_n <= 1'b1;
        tick();

        // Quiet outputs and zeroed registers out of reset
        check_value("start_write", 32'h0, 32'(start_write));
        check_value("write_valid", 32'h0, 32'(write_valid));
        check_value("write_done", 32'h0, 32'(write_done));
        check_value("pslverr", 32'h0, 32'(pslverr));
        models_on = 1'b1;
        reg_expect("prdata fb_base", reg_fb_base, 32'h0);
        reg_expect("prdata fb_width", reg_fb_width, 32'h0);
        reg_expect("prdata write_count", reg_write_count, 32'h0);

        reg_write(reg_fb_base, 32'h1000_0000);
        reg_write(reg_fb_width, 32'habcd_0280);
        ref_base  = 32'h1000_0000;
        ref_width = 16'h0280;
        reg_expect("prdata fb_base", reg_fb_base, 32'h1000_0000);
        reg_expect("prdata fb_width", reg_fb_width, 32'h0000_0280);
        apb_transfer(1'b0, paddr_w'(12), 32'h0, rdata, err);
        check_value("pslverr", 32'h1, 32'(err));
        check_value("prdata", 32'h0, rdata);
        apb_transfer(1'b1, paddr_w'(12), 32'h5a5a_5a5a, rdata, err);
        check_value("pslverr", 32'h1, 32'(err));

        // All cores at once, granted in index order
        tick();
        for (int k = 0; k < num_cores; k++) begin
            post_request(core_id_w'(k));
        end
        wait_idle();
        reg_expect("prdata write_count", reg_write_count, 32'(num_cores));
        clear_count();

        while (random_issued < num_random_writes) begin
            if (rand_below(2) == 0) reprogram_fb();
            burst = 8 + rand_below(25);
            if (burst > num_random_writes - random_issued) begin
                burst = num_random_writes - random_issued;
            end
            requests_left = burst;
            random_issued += burst;
            wait_idle();
            reg_expect("prdata write_count", reg_write_count, 32'(ref_count));
            if (rand_below(6) == 0) clear_count();
        end

        $display("Test passed");
        $finish;
    end

endmodule

//--- list.f
verilog/frag_write_pkg.sv
verilog/write_arb_fsm.sv
verilog/core_select.sv
verilog/fb_address_unit.sv
verilog/write_counter.sv
verilog/apb_regs.sv
verilog/frag_write_top.sv
tests/tb_frag_write.sv

//--- Makefile
SIM = obj_dir/Vtb_frag_write

all: run

$(SIM): list.f $(wildcard verilog/*.sv tests/*.sv)
	verilator --binary --timing --top-module tb_frag_write -f list.f \
		-Mdir obj_dir -o Vtb_frag_write

run: $(SIM)
	./$(SIM) | tee sim.log
	grep -q "^Test passed$$" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: all run clean
